// File: dv/test_input.txt
# L byte address and eight instruction words, K key value, R reset then run
# W expected ledr and expected hex, every number in hex
W 000 fedead
# Every ALUR and immediate operation, chained through r3, compares packed into r5
L 100 805a3c01 80ff0602 80000404 00800312 00a00334 00c40334 00980331 00940332
L 120 00c00334 00900332 00b00331 00b40334 00b80332 900ff033 94700133 9800ff33
L 140 80fffe33 00240521 00280612 00800555 00800556 00200644 00800555 00800556
L 160 002c0612 00800555 00800556 68f00003 68f02005 30005d0f 00000000 00000000
R
W 00b 007a0c
# Store to data memory, overwrite the register, load back and add
L 100 800abc01 68004001 80003301 48004002 80001122 68f00002 68f02001 3000470f
R
W 033 000acd
# Countdown with BNE, taken BLT and BLE, BEQ not taken
L 100 80000501 00800221 80ffff11 2cfffd10 24000112 80010022 28000111 80020022
L 120 20000112 80100022 68f00002 30004b0f 00000000 00000000 00000000 00000000
R
W 000 00100f
# JAL to a subroutine at 110 and back through r14
L 100 3000440e 68f0200e 3000420f 00000000 80005503 68f00003 300000ed 00000000
R
W 104 000055
# Buttons 0 and 2 pressed
K a
L 100 48f08001 68f02001 3000420f 00000000 00000000 00000000 00000000 00000000
R
W 005 fedead

// File: filelist.f
hw/isa_pkg.sv
hw/soc_pkg.sv
hw/fetch_unit.sv
hw/decoder.sv
hw/reg_file.sv
hw/alu.sv
hw/branch_unit.sv
hw/data_mem_io.sv
hw/cpu_top.sv
dv/cpu_top_assertions.sv
dv/cpu_top_tb.sv

// File: Bender.yml
package:
  name: cpu_top

sources:
  - hw/isa_pkg.sv
  - hw/soc_pkg.sv
  - hw/fetch_unit.sv
  - hw/decoder.sv
  - hw/reg_file.sv
  - hw/alu.sv
  - hw/branch_unit.sv
  - hw/data_mem_io.sv
  - hw/cpu_top.sv
  - target: simulation
    files:
      - dv/cpu_top_assertions.sv
      - dv/cpu_top_tb.sv

// File: dv/cpu_top_tb.sv
module cpu_top_tb
  import isa_pkg::*, soc_pkg::*;
();

  localparam int wait_limit = 2000;

  logic       clk;
  logic       reset;
  logic       run;
  imem_load_t load;
  key_t       key;
  ledr_t      ledr;
  hex_t       hex;

  int errors;
  int checks;

  cpu_top cpu_top_i (
    .clk, .reset, .run, .load, .key, .ledr, .hex
  );

  always #4 clk = ~clk;

  // Inputs change one unit after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic compare_value(
    input string what,
    input word_t actual,
    input word_t expected
  );
    if (actual !== expected) begin
      errors++;
      $display("error at %0t: %s is %h, expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic apply_reset();
    run   = 1'b0;
    reset = 1'b1;
    repeat (3) next_cycle();
    reset = 1'b0;
  endtask

  // Byte address in the file, word index on the load port
  task automatic load_word(input word_t addr, input word_t data);
    load.we   = 1'b1;
    load.addr = addr[mem_idx_bits+1:2];
    load.data = data;
    next_cycle();
    load.we   = 1'b0;
  endtask

  // The program ends in a self loop, so the outputs settle eventually
  task automatic wait_outputs(input ledr_t exp_ledr, input hex_t exp_hex);
    int cycles;
    cycles = 0;
    while ((ledr !== exp_ledr || hex !== exp_hex) && cycles < wait_limit) begin
      next_cycle();
      cycles++;
    end
    if (ledr !== exp_ledr || hex !== exp_hex) begin
      $display("outputs did not reach the expected values within %0d cycles", wait_limit);
    end
    checks++;
    compare_value("ledr", ledr, exp_ledr);
    compare_value("hex", hex, exp_hex);
  endtask

  initial begin
    int               fd;
    int               code;
    logic [7:0]       cmd;
    logic [8*128-1:0] line;
    word_t            addr;
    word_t            word;
    logic [31:0]      value;
    logic [31:0]      exp_ledr;
    logic [31:0]      exp_hex;

    clk    = 1'b0;
    reset  = 1'b1;
    run    = 1'b0;
    load   = '0;
    key    = 4'hf;
    errors = 0;
    checks = 0;
    repeat (3) next_cycle();
    reset = 1'b0;

    fd = $fopen("dv/test_input.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open dv/test_input.txt");
    end else begin
      code = $fscanf(fd, " %c", cmd);
      while (code == 1) begin
        case (cmd)
          "#": code = $fgets(line, fd);
          "L": begin
            // Eight words per line at consecutive addresses
            run  = 1'b0;
            code = $fscanf(fd, "%h", addr);
            for (int i = 0; i < 8; i++) begin
              code = $fscanf(fd, "%h", word);
              load_word(addr + 4 * i, word);
            end
          end
          "K": begin
            code = $fscanf(fd, "%h", value);
            key  = value[3:0];
          end
          "R": begin
            apply_reset();
            next_cycle();
            run = 1'b1;
          end
          "W": begin
            code = $fscanf(fd, "%h %h", exp_ledr, exp_hex);
            wait_outputs(exp_ledr[9:0], exp_hex[23:0]);
          end
          default: begin
            errors++;
            $display("unknown command %c in dv/test_input.txt", cmd);
            code = $fgets(line, fd);
          end
        endcase
        code = $fscanf(fd, " %c", cmd);
      end
      $fclose(fd);
    end

    if (checks == 0) begin
      errors++;
      $display("no output checks were run");
    end
    errors += cpu_top_i.cpu_top_assertions_i.failures;
    $display("%0d output checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: dv/cpu_top_assertions.sv
module cpu_top_assertions
  import isa_pkg::*, soc_pkg::*;
(
  input logic     clk,
  input logic     reset,
  input logic     run,
  input word_t    pc,
  input mem_req_t mem_req,
  input ledr_t    ledr,
  input hex_t     hex
);

  int failures = 0;

  pc_aligned: assert property (
    @(posedge clk) disable iff (reset) pc[1:0] == 2'b00
  ) else begin
    failures++;
    $error("pc is not word aligned");
  end

  // No instruction completes while run is low
  pc_holds: assert property (
    @(posedge clk) disable iff (reset) !run |=> $stable(pc)
  ) else begin
    failures++;
    $error("pc moved while run was low");
  end

  // LW and SW decode to separate strobes
  mem_strobes_exclusive: assert property (
    @(posedge clk) disable iff (reset) run |-> !(mem_req.rd && mem_req.wr)
  ) else begin
    failures++;
    $error("memory read and write requested together");
  end

  reset_values: assert property (
    @(posedge clk) $fell(reset) |-> (ledr == '0 && hex == hex_reset)
  ) else begin
    failures++;
    $error("ledr or hex not at its reset value after reset");
  end

endmodule

bind cpu_top cpu_top_assertions cpu_top_assertions_i (
  .clk, .reset, .run, .pc, .mem_req, .ledr, .hex
);

// File: hw/cpu_top.sv
module cpu_top
  import isa_pkg::*, soc_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       run,
  input  imem_load_t load,
  input  key_t       key,
  output ledr_t      ledr,
  output hex_t       hex
);

  word_t    pc;
  word_t    inst;
  word_t    next_pc;
  dec_t     dec;
  word_t    rv1;
  word_t    rv2;
  word_t    alu_out;
  word_t    rdata;
  word_t    wb_data;
  mem_req_t mem_req;

  fetch_unit fetch_unit_i (
    .clk, .reset, .run, .load, .next_pc, .pc, .inst
  );

  decoder decoder_i (.inst, .dec);

  reg_file reg_file_i (
    .clk, .reset, .run, .dec, .wb_data, .rv1, .rv2
  );

  // ALU and branch unit see the same operands
  alu alu_i (.dec, .pc, .rv1, .rv2, .alu_out);

  branch_unit branch_unit_i (.dec, .pc, .rv1, .rv2, .next_pc);

  // Store data always comes from rt
  assign mem_req.addr  = alu_out;
  assign mem_req.wdata = rv2;
  assign mem_req.rd    = dec.rd_mem;
  assign mem_req.wr    = dec.wr_mem;

  data_mem_io data_mem_io_i (
    .clk, .reset, .run, .req(mem_req), .key, .rdata, .ledr, .hex
  );

  assign wb_data = dec.rd_mem ? rdata : alu_out;

endmodule

// File: hw/data_mem_io.sv
module data_mem_io
  import isa_pkg::*, soc_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     run,
  input  mem_req_t req,
  input  key_t     key,
  output word_t    rdata,
  output ledr_t    ledr,
  output hex_t     hex
);

  word_t    dmem [mem_words];
  mem_idx_t idx;
  logic     sel_hex;
  logic     sel_ledr;
  logic     sel_key;
  logic     store;

  assign idx      = req.addr[mem_idx_bits+1:2];
  assign sel_hex  = (req.addr == addr_hex);
  assign sel_ledr = (req.addr == addr_ledr);
  assign sel_key  = (req.addr == addr_key);
  assign store    = run && req.wr;

  // Memory is only written when no I/O register is hit
  always_ff @(posedge clk) begin
    if (store && !sel_hex && !sel_ledr) begin
      dmem[idx] <= req.wdata;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ledr <= '0;
      hex  <= hex_reset;
    end else if (store) begin
      if (sel_ledr) ledr <= req.wdata[9:0];
      if (sel_hex)  hex  <= req.wdata[23:0];
    end
  end

  // Keys are active low on the board, so they are inverted here
  assign rdata = !req.rd ? '0 :
                 sel_key ? {28'b0, ~key} :
                           dmem[idx];

endmodule

// File: hw/branch_unit.sv
module branch_unit
  import isa_pkg::*;
(
  input  dec_t  dec,
  input  word_t pc,
  input  word_t rv1,
  input  word_t rv2,
  output word_t next_pc
);

  logic  taken;
  word_t pc_plus;
  word_t imm_x4;

  assign pc_plus = pc + inst_size;
  assign imm_x4  = {dec.imm[29:0], 2'b00};

  // Signed compare selected by the primary opcode
  always_comb begin
    case (dec.op1)
      OP1_BEQ: taken = (rv1 == rv2);
      OP1_BLT: taken = ($signed(rv1) < $signed(rv2));
      OP1_BLE: taken = ($signed(rv1) <= $signed(rv2));
      OP1_BNE: taken = (rv1 != rv2);
      default: taken = 1'b0;
    endcase
  end

  assign next_pc = (dec.is_br && taken) ? pc_plus + imm_x4 :
                   dec.is_jmp           ? rv1 + imm_x4 :
                                          pc_plus;

endmodule

// File: hw/alu.sv
module alu
  import isa_pkg::*;
(
  input  dec_t  dec,
  input  word_t pc,
  input  word_t rv1,
  input  word_t rv2,
  output word_t alu_out
);

  logic signed [31:0] a;
  logic signed [31:0] b;

  assign a = rv1;
  assign b = rv2;

  always_comb begin
    alu_out = '0;
    case (dec.op1)
      OP1_ALUR: begin
        case (dec.op2)
          // Comparisons are signed and give 0 or 1
          OP2_EQ:   alu_out = {31'b0, a == b};
          OP2_LT:   alu_out = {31'b0, a < b};
          OP2_LE:   alu_out = {31'b0, a <= b};
          OP2_NE:   alu_out = {31'b0, a != b};
          OP2_ADD:  alu_out = rv1 + rv2;
          OP2_SUB:  alu_out = rv1 - rv2;
          OP2_AND:  alu_out = rv1 & rv2;
          OP2_OR:   alu_out = rv1 | rv2;
          OP2_XOR:  alu_out = rv1 ^ rv2;
          OP2_NAND: alu_out = ~(rv1 & rv2);
          OP2_NOR:  alu_out = ~(rv1 | rv2);
          OP2_NXOR: alu_out = ~(rv1 ^ rv2);
          OP2_RSHF: alu_out = a >>> rv2;
          OP2_LSHF: alu_out = rv1 << rv2;
          default:  alu_out = '0;
        endcase
      end
      // Address generation shares the adder with ADDI
      OP1_LW, OP1_SW, OP1_ADDI: alu_out = rv1 + dec.imm;
      OP1_ANDI: alu_out = rv1 & dec.imm;
      OP1_ORI:  alu_out = rv1 | dec.imm;
      OP1_XORI: alu_out = rv1 ^ dec.imm;
      // Link value
      OP1_JAL:  alu_out = pc + inst_size;
      default:  alu_out = '0;
    endcase
  end

endmodule

// File: hw/reg_file.sv
module reg_file
  import isa_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  run,
  input  dec_t  dec,
  input  word_t wb_data,
  output word_t rv1,
  output word_t rv2
);

  word_t regs [16];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (run && dec.wr_reg) begin
      regs[dec.wreg] <= wb_data;
    end
  end

  // Reads are combinational, rs on port 1 and rt on port 2
  assign rv1 = regs[dec.rs];
  assign rv2 = regs[dec.rt];

endmodule

// File: hw/decoder.sv
module decoder
  import isa_pkg::*;
(
  input  word_t inst,
  output dec_t  dec
);

  op1_t     op1;
  op2_t     op2;
  imm_t     imm;
  reg_idx_t rd;
  reg_idx_t rs;
  reg_idx_t rt;
  logic     is_br;
  logic     wr_mem;

  // Field extraction, imm overlaps op2 and rd
  assign op1 = inst[31:26];
  assign op2 = inst[25:18];
  assign imm = inst[23:8];
  assign rd  = inst[11:8];
  assign rs  = inst[7:4];
  assign rt  = inst[3:0];

  assign is_br  = (op1 == OP1_BEQ) || (op1 == OP1_BLT) ||
                  (op1 == OP1_BLE) || (op1 == OP1_BNE);
  assign wr_mem = (op1 == OP1_SW);

  always_comb begin
    dec.op1    = op1;
    dec.op2    = op2;
    dec.rs     = rs;
    dec.rt     = rt;
    // ALUR writes rd, everything else writes rt
    dec.wreg   = (op1 == OP1_ALUR) ? rd : rt;
    dec.imm    = {{16{imm[15]}}, imm};
    dec.is_br  = is_br;
    dec.is_jmp = (op1 == OP1_JAL);
    dec.rd_mem = (op1 == OP1_LW);
    dec.wr_mem = wr_mem;
    dec.wr_reg = !(is_br || wr_mem);
  end

endmodule

// File: hw/fetch_unit.sv
module fetch_unit
  import isa_pkg::*, soc_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       run,
  input  imem_load_t load,
  input  word_t      next_pc,
  output word_t      pc,
  output word_t      inst
);

  word_t imem [mem_words];

  // Program counter, held at start_pc until run goes high
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc <= start_pc;
    end else if (run) begin
      pc <= next_pc;
    end
  end

  // Program load
  always_ff @(posedge clk) begin
    if (load.we) begin
      imem[load.addr] <= load.data;
    end
  end

  // Asynchronous read at the current pc
  assign inst = imem[pc[mem_idx_bits+1:2]];

endmodule

// File: hw/soc_pkg.sv
package soc_pkg;

  import isa_pkg::*;

  // Both memories are word arrays indexed by address bits 9 to 2
  localparam int mem_words    = 256;
  localparam int mem_idx_bits = $clog2(mem_words);

  typedef logic [mem_idx_bits-1:0] mem_idx_t;
  typedef logic [23:0] hex_t;
  typedef logic [9:0]  ledr_t;
  typedef logic [3:0]  key_t;

  localparam word_t start_pc  = 32'h100;
  localparam word_t addr_hex  = 32'hFFFFF000;
  localparam word_t addr_ledr = 32'hFFFFF020;
  localparam word_t addr_key  = 32'hFFFFF080;
  localparam hex_t  hex_reset = 24'hFEDEAD;

  typedef struct packed {
    word_t addr;
    word_t wdata;
    logic  rd;
    logic  wr;
  } mem_req_t;

  // Instruction memory load port, addr is a word index
  typedef struct packed {
    logic     we;
    mem_idx_t addr;
    word_t    data;
  } imem_load_t;

endpackage

// File: hw/isa_pkg.sv
package isa_pkg;

  // Widths fixed by the instruction set
  typedef logic [31:0] word_t;
  typedef logic [3:0]  reg_idx_t;
  typedef logic [15:0] imm_t;
  typedef logic [5:0]  op1_t;
  typedef logic [7:0]  op2_t;

  localparam word_t inst_size = 32'd4;

  // Primary opcodes
  localparam op1_t OP1_ALUR = 6'b000000;
  localparam op1_t OP1_BEQ  = 6'b001000;
  localparam op1_t OP1_BLT  = 6'b001001;
  localparam op1_t OP1_BLE  = 6'b001010;
  localparam op1_t OP1_BNE  = 6'b001011;
  localparam op1_t OP1_JAL  = 6'b001100;
  localparam op1_t OP1_LW   = 6'b010010;
  localparam op1_t OP1_SW   = 6'b011010;
  localparam op1_t OP1_ADDI = 6'b100000;
  localparam op1_t OP1_ANDI = 6'b100100;
  localparam op1_t OP1_ORI  = 6'b100101;
  localparam op1_t OP1_XORI = 6'b100110;

  // Secondary opcodes, only meaningful with OP1_ALUR
  localparam op2_t OP2_EQ   = 8'b00001000;
  localparam op2_t OP2_LT   = 8'b00001001;
  localparam op2_t OP2_LE   = 8'b00001010;
  localparam op2_t OP2_NE   = 8'b00001011;
  localparam op2_t OP2_ADD  = 8'b00100000;
  localparam op2_t OP2_AND  = 8'b00100100;
  localparam op2_t OP2_OR   = 8'b00100101;
  localparam op2_t OP2_XOR  = 8'b00100110;
  localparam op2_t OP2_SUB  = 8'b00101000;
  localparam op2_t OP2_NAND = 8'b00101100;
  localparam op2_t OP2_NOR  = 8'b00101101;
  localparam op2_t OP2_NXOR = 8'b00101110;
  localparam op2_t OP2_RSHF = 8'b00110000;
  localparam op2_t OP2_LSHF = 8'b00110001;

  // Decoded instruction
  typedef struct packed {
    op1_t     op1;
    op2_t     op2;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t wreg;
    word_t    imm;
    logic     is_br;
    logic     is_jmp;
    logic     rd_mem;
    logic     wr_mem;
    logic     wr_reg;
  } dec_t;

endpackage
